//--- src.f
+incdir+sim
src/player_pkg.sv
src/beat_timer.sv
src/melody_rom.sv
src/song_sequencer.sv
src/pitch_divider_table.sv
src/note_player_top.sv
sim/tb_note_player.sv

//--- Bender.yml
package:
  name: note_player

sources:
  - files:
      - src/player_pkg.sv
      - src/beat_timer.sv
      - src/melody_rom.sv
      - src/song_sequencer.sv
      - src/pitch_divider_table.sv
      - src/note_player_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_note_player.sv

//--- sim/tb_song_tables.svh
`ifndef TB_SONG_TABLES_SVH
`define TB_SONG_TABLES_SVH

localparam int STAR_COUNT = player_pkg::STAR_LEN;
localparam int SKY_COUNT  = player_pkg::SKY_LEN;

// note codes as in note_e, position 0 sits in the top nibble
localparam logic [4*STAR_COUNT-1:0] STAR_NOTES = {
	4'd5, 4'd3, 4'd3, 4'd0, 4'd5, 4'd2, 4'd2,  // phrase 1
	4'd0, 4'd3, 4'd2, 4'd2, 4'd1, 4'd1, 4'd0,
	4'd1, 4'd7, 4'd0, 4'd6, 4'd7, 4'd1, 4'd7,  // phrase 2
	4'd1, 4'd0, 4'd1, 4'd2, 4'd3, 4'd3, 4'd0,
	4'd5, 4'd3, 4'd3, 4'd0, 4'd5, 4'd2, 4'd2,  // phrase 3
	4'd0, 4'd3, 4'd2, 4'd2, 4'd1, 4'd1, 4'd0,
	4'd1, 4'd7, 4'd6, 4'd7, 4'd1, 4'd7,        // phrase 4
	4'd7, 4'd1, 4'd1, 4'd2, 4'd1, 4'd0
};

localparam logic [4*SKY_COUNT-1:0] SKY_NOTES = {
	4'd0, 4'd6, 4'd7, 4'd8, 4'd8, 4'd8, 4'd7, 4'd8, 4'd8,        // pickup and phrase 1
	4'd10, 4'd10, 4'd7, 4'd7, 4'd7, 4'd7, 4'd7, 4'd7, 4'd0,
	4'd3, 4'd3, 4'd6, 4'd6, 4'd5, 4'd6, 4'd6, 4'd8,              // phrase 2
	4'd8, 4'd5, 4'd5, 4'd5, 4'd5, 4'd5, 4'd5, 4'd0,
	4'd3, 4'd3, 4'd4, 4'd4, 4'd4, 4'd3, 4'd4, 4'd8,              // phrase 3
	4'd8, 4'd8, 4'd3, 4'd3, 4'd3, 4'd3, 4'd3, 4'd0,
	4'd8, 4'd8, 4'd8, 4'd7, 4'd7, 4'd7, 4'd13, 4'd13, 4'd13,     // phrase 4
	4'd7, 4'd7, 4'd7, 4'd7, 4'd7, 4'd7, 4'd7, 4'd7, 4'd0
};

// divide counts for codes 0 to 14, rest first
localparam logic [20*15-1:0] DIVIDERS = {
	20'd0,
	20'd76628, 20'd68259, 20'd60606, 20'd57306,  // do re mi fa
	20'd51020, 20'd45454, 20'd40485,             // so la si
	20'd38240, 20'd34071, 20'd30349, 20'd28653,  // high do to high fa
	20'd25542,                                   // high so
	20'd54054, 20'd48192                         // fa sharp, so sharp
};

function automatic logic [3:0] table_note(input player_pkg::song_e song, input int pos);
	logic [3:0] code;
	code = 4'd0;
	if (song == player_pkg::SONG_STAR && pos < STAR_COUNT)
		code = STAR_NOTES[4*(STAR_COUNT-1-pos) +: 4];
	else if (song == player_pkg::SONG_SKY && pos < SKY_COUNT)
		code = SKY_NOTES[4*(SKY_COUNT-1-pos) +: 4];
	return code; // rest past the end or for other tunes
endfunction

function automatic logic [19:0] table_divider(input logic [3:0] code);
	logic [19:0] div;
	div = 20'd0;
	if (code <= 4'd14)
		div = DIVIDERS[20*(14-code) +: 20];
	return div;
endfunction

`endif

//--- sim/tb_note_player.sv
`timescale 1ns/1ps
`default_nettype none

module tb_note_player;

	localparam int STAR_STEPS = 3;
	localparam int SKY_STEPS  = 2;

	logic                         clk_10Hz;
	logic                         reset;
	logic                         valid;
	player_pkg::song_e            mode_sel;
	player_pkg::note_e            note;
	logic [player_pkg::DIV_W-1:0] note_div;
	logic                         finished;

	`include "tb_song_tables.svh"

	// star runs with about half the steps valid plus idle checks and resets
	localparam int STAR_RUN   = 2 * STAR_COUNT * STAR_STEPS;
	localparam int SKY_RUN    = SKY_COUNT * SKY_STEPS;
	localparam int OTHER_RUN  = 200;
	localparam int MAX_CYCLES = 3 * (STAR_RUN + SKY_RUN + OTHER_RUN);

	string       test_name;
	logic [31:0] lcg_state;
	int          cycle_count = 0;

	int          model_phase;  // reference model state
	int          model_pos;
	logic [3:0]  model_note;
	logic [19:0] model_div;
	logic        model_finished;

	note_player_top #(
		.STAR_STEPS (STAR_STEPS),
		.SKY_STEPS  (SKY_STEPS)
	) dut (
		.clk_10Hz (clk_10Hz),
		.reset    (reset),
		.valid    (valid),
		.mode_sel (mode_sel),
		.note     (note),
		.note_div (note_div),
		.finished (finished)
	);

	initial begin
		clk_10Hz = 1'b0;
		forever #10 clk_10Hz = ~clk_10Hz;
	end

	function automatic logic next_random_bit();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[16]; // bit 16 of the new state
	endfunction

	function automatic int slot_last(input player_pkg::song_e song);
		if (song == player_pkg::SONG_STAR)
			return STAR_STEPS - 1;
		else if (song == player_pkg::SONG_SKY)
			return SKY_STEPS - 1;
		return 0;
	endfunction

	function automatic int tune_length(input player_pkg::song_e song);
		if (song == player_pkg::SONG_STAR)
			return STAR_COUNT;
		else if (song == player_pkg::SONG_SKY)
			return SKY_COUNT;
		return 0;
	endfunction

	task automatic value_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("FAILED %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model
	always @(posedge clk_10Hz or negedge reset) begin
		if (!reset) begin
			model_phase    <= 0;
			model_pos      <= 0;
			model_note     <= 4'd0;
			model_div      <= 20'd0;
			model_finished <= 1'b0;
		end else begin
			model_div <= table_divider(model_note); // every edge whether valid or not
			if (valid) begin
				model_phase <= (model_phase >= slot_last(mode_sel)) ? 0 : model_phase + 1;
				if (model_phase == 0 && tune_length(mode_sel) != 0 && !model_finished) begin
					model_note <= table_note(mode_sel, model_pos);
					model_pos  <= model_pos + 1;
					if (model_pos + 1 == tune_length(mode_sel))
						model_finished <= 1'b1;
				end else begin
					model_note <= 4'd0; // gap, finished or empty tune
				end
			end
		end
	end

	// outputs against the model half a cycle after the edge
	always @(negedge clk_10Hz) begin
		assert (note == model_note) else value_mismatch("note", model_note, note);
		assert (note_div == model_div) else value_mismatch("note_div", model_div, note_div);
		assert (finished == model_finished)
			else value_mismatch("finished", model_finished, finished);
	end

	always @(posedge clk_10Hz) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: tests still running after %0d cycles", MAX_CYCLES);
			$display("Result: FAILED");
			$fatal(1);
		end
	end

	task automatic check_idle_outputs();
		assert (note == player_pkg::NOTE_REST) else value_mismatch("idle note", 0, note);
		assert (note_div == '0) else value_mismatch("idle note_div", 0, note_div);
		assert (!finished) else value_mismatch("idle finished", 0, finished);
	endtask

	task automatic apply_reset();
		valid = 1'b0;
		reset = 1'b0;
		repeat (4) @(posedge clk_10Hz);
		check_idle_outputs(); // still inside reset
		#2 reset = 1'b1;
	endtask

	// plays the selected tune until finished and counts the valid steps
	task automatic run_until_finished(input logic random_valid, output int steps);
		steps = 0;
		while (!finished) begin
			valid = random_valid ? next_random_bit() : 1'b1;
			@(posedge clk_10Hz);
			if (valid)
				steps++;
			#2;
		end
	endtask

	task automatic hold_after_end(input int cycles, input logic random_valid);
		repeat (cycles) begin
			valid = random_valid ? next_random_bit() : 1'b1;
			@(posedge clk_10Hz);
			#2;
			assert (finished) else value_mismatch("finished held", 1, finished);
		end
	endtask

	initial begin
		int sky_steps;
		int star_steps;
		lcg_state = 32'd70994;
		reset     = 1'b0;
		valid     = 1'b0;
		mode_sel  = player_pkg::SONG_NONE;
		test_name = "reset";
		apply_reset();
		@(posedge clk_10Hz);
		#2 check_idle_outputs();

		test_name = "idle_none";
		valid     = 1'b1;
		repeat (20) begin
			@(posedge clk_10Hz);
			#2 check_idle_outputs();
		end
		test_name = "idle_spare";
		mode_sel  = player_pkg::SONG_SPARE;
		repeat (20) begin
			@(posedge clk_10Hz);
			#2 check_idle_outputs();
		end

		//////////////////////////////////////////////////////////////////////
		// second tune with every step valid
		apply_reset();
		test_name = "sky_tune";
		mode_sel  = player_pkg::SONG_SKY;
		run_until_finished(1'b0, sky_steps);
		assert (sky_steps == (SKY_COUNT - 1) * SKY_STEPS + 1)
			else value_mismatch("steps to finish", (SKY_COUNT - 1) * SKY_STEPS + 1, sky_steps);
		test_name = "sky_after_end";
		hold_after_end(20, 1'b0);

		//////////////////////////////////////////////////////////////////////
		// first tune with random valid
		apply_reset();
		test_name = "star_tune";
		mode_sel  = player_pkg::SONG_STAR;
		run_until_finished(1'b1, star_steps);
		assert (star_steps == (STAR_COUNT - 1) * STAR_STEPS + 1)
			else value_mismatch("steps to finish", (STAR_COUNT - 1) * STAR_STEPS + 1, star_steps);
		test_name = "star_after_end";
		hold_after_end(30, 1'b1);
		test_name = "switch_after_end";
		mode_sel  = player_pkg::SONG_SKY; // a new tune must not restart
		hold_after_end(10, 1'b0);

		test_name = "final_reset";
		mode_sel  = player_pkg::SONG_NONE;
		apply_reset();
		repeat (2) @(posedge clk_10Hz);
		#2 check_idle_outputs();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/note_player_top.sv
`timescale 1ns/1ps
`default_nettype none

module note_player_top #(
	parameter int STAR_STEPS = 3, // steps per note, first tune
	parameter int SKY_STEPS  = 2  // steps per note, second tune
) (
	input  logic                         clk_10Hz,
	input  logic                         reset,
	input  logic                         valid,
	input  player_pkg::song_e            mode_sel,
	output player_pkg::note_e            note,
	output logic [player_pkg::DIV_W-1:0] note_div,
	output logic                         finished
);

	logic beat; // step that starts a note slot
	logic gap;  // remaining steps of the slot

	////////////////////////////////////////////////////////////////////////
	// input side
	beat_timer #(
		.STAR_STEPS (STAR_STEPS),
		.SKY_STEPS  (SKY_STEPS)
	) u_timer (
		.clk_10Hz (clk_10Hz),
		.reset    (reset),
		.valid    (valid),
		.song     (mode_sel),
		.beat     (beat),
		.gap      (gap)
	);

	////////////////////////////////////////////////////////////////////////
	// processing
	song_sequencer u_seq (
		.clk_10Hz (clk_10Hz),
		.reset    (reset),
		.song     (mode_sel),
		.beat     (beat),
		.gap      (gap),
		.note     (note),
		.finished (finished)
	);

	////////////////////////////////////////////////////////////////////////
	// output side
	pitch_divider_table u_div (
		.clk_10Hz (clk_10Hz),
		.reset    (reset),
		.note     (note),
		.note_div (note_div)
	);

endmodule

`default_nettype wire

//--- src/pitch_divider_table.sv
`timescale 1ns/1ps
`default_nettype none

module pitch_divider_table (
	input  logic                         clk_10Hz,
	input  logic                         reset,
	input  player_pkg::note_e            note,
	output logic [player_pkg::DIV_W-1:0] note_div
);

	// divide counts for the tone generator, one cycle behind the note
	always_ff @(posedge clk_10Hz or negedge reset) begin
		if (!reset) begin
			note_div <= '0;
		end else begin
			case (note)
				player_pkg::NOTE_DO:       note_div <= 20'd76628;
				player_pkg::NOTE_RE:       note_div <= 20'd68259;
				player_pkg::NOTE_MI:       note_div <= 20'd60606;
				player_pkg::NOTE_FA:       note_div <= 20'd57306;
				player_pkg::NOTE_SO:       note_div <= 20'd51020;
				player_pkg::NOTE_LA:       note_div <= 20'd45454;
				player_pkg::NOTE_SI:       note_div <= 20'd40485;
				player_pkg::NOTE_HI_DO:    note_div <= 20'd38240; // upper octave
				player_pkg::NOTE_HI_RE:    note_div <= 20'd34071;
				player_pkg::NOTE_HI_MI:    note_div <= 20'd30349;
				player_pkg::NOTE_HI_FA:    note_div <= 20'd28653;
				player_pkg::NOTE_HI_SO:    note_div <= 20'd25542;
				player_pkg::NOTE_FA_SHARP: note_div <= 20'd54054; // mid fa sharp
				player_pkg::NOTE_SO_SHARP: note_div <= 20'd48192; // mid so sharp
				default:                   note_div <= '0;        // rest is silent
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/song_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module song_sequencer (
	input  logic              clk_10Hz,
	input  logic              reset,
	input  player_pkg::song_e song,
	input  logic              beat,
	input  logic              gap,
	output player_pkg::note_e note,
	output logic              finished
);

	logic [player_pkg::POS_W-1:0] pos;      // next note to play
	logic [player_pkg::POS_W-1:0] pos_next;
	logic [player_pkg::POS_W-1:0] tune_len;
	player_pkg::note_e            rom_note;
	logic                         playing;

	melody_rom u_rom (
		.pos  (pos),
		.song (song),
		.note (rom_note)
	);

	always_comb begin
		case (song)
			player_pkg::SONG_STAR: tune_len = player_pkg::STAR_LEN;
			player_pkg::SONG_SKY:  tune_len = player_pkg::SKY_LEN;
			default:               tune_len = '0; // nothing to play
		endcase
	end

	assign pos_next = pos + 1'b1;
	assign playing  = (tune_len != '0) && !finished;

	////////////////////////////////////////////////////////////////////////
	// position, current note and end of tune
	always_ff @(posedge clk_10Hz or negedge reset) begin
		if (!reset) begin
			note     <= player_pkg::NOTE_REST;
			pos      <= '0;
			finished <= 1'b0;
		end else if (beat) begin
			if (playing) begin
				note <= rom_note;
				pos  <= pos_next;
				if (pos_next >= tune_len) // last stored note goes out now
					finished <= 1'b1;
			end else begin
				note <= player_pkg::NOTE_REST;
			end
		end else if (gap) begin
			note <= player_pkg::NOTE_REST; // articulation rest
		end
	end

endmodule

`default_nettype wire

//--- src/melody_rom.sv
`timescale 1ns/1ps
`default_nettype none

module melody_rom (
	input  logic [player_pkg::POS_W-1:0] pos,
	input  player_pkg::song_e            song,
	output player_pkg::note_e            note
);

	always_comb begin
		note = player_pkg::NOTE_REST; // past the end or no tune
		case (song)
			player_pkg::SONG_STAR: begin
				case (pos)
					0:  note = player_pkg::NOTE_SO;
					1:  note = player_pkg::NOTE_MI;
					2:  note = player_pkg::NOTE_MI;
					3:  note = player_pkg::NOTE_REST;
					4:  note = player_pkg::NOTE_SO;
					5:  note = player_pkg::NOTE_RE;
					6:  note = player_pkg::NOTE_RE;
					7:  note = player_pkg::NOTE_REST;
					8:  note = player_pkg::NOTE_MI;
					9:  note = player_pkg::NOTE_RE;
					10: note = player_pkg::NOTE_RE;
					11: note = player_pkg::NOTE_DO;
					12: note = player_pkg::NOTE_DO;
					13: note = player_pkg::NOTE_REST;
					//////////////////////////////////////////////////////////////////////
					14: note = player_pkg::NOTE_DO;
					15: note = player_pkg::NOTE_SI;
					16: note = player_pkg::NOTE_REST;
					17: note = player_pkg::NOTE_LA;
					18: note = player_pkg::NOTE_SI;
					19: note = player_pkg::NOTE_DO;
					20: note = player_pkg::NOTE_SI;
					21: note = player_pkg::NOTE_DO;
					22: note = player_pkg::NOTE_REST;
					23: note = player_pkg::NOTE_DO;
					24: note = player_pkg::NOTE_RE;
					25: note = player_pkg::NOTE_MI;
					26: note = player_pkg::NOTE_MI;
					27: note = player_pkg::NOTE_REST;
					//////////////////////////////////////////////////////////////////////
					28: note = player_pkg::NOTE_SO;
					29: note = player_pkg::NOTE_MI;
					30: note = player_pkg::NOTE_MI;
					31: note = player_pkg::NOTE_REST;
					32: note = player_pkg::NOTE_SO;
					33: note = player_pkg::NOTE_RE;
					34: note = player_pkg::NOTE_RE;
					35: note = player_pkg::NOTE_REST;
					36: note = player_pkg::NOTE_MI;
					37: note = player_pkg::NOTE_RE;
					38: note = player_pkg::NOTE_RE;
					39: note = player_pkg::NOTE_DO;
					40: note = player_pkg::NOTE_DO;
					41: note = player_pkg::NOTE_REST;
					//////////////////////////////////////////////////////////////////////
					42: note = player_pkg::NOTE_DO;
					43: note = player_pkg::NOTE_SI;
					44: note = player_pkg::NOTE_LA;
					45: note = player_pkg::NOTE_SI;
					46: note = player_pkg::NOTE_DO;
					47: note = player_pkg::NOTE_SI;
					48: note = player_pkg::NOTE_SI;
					49: note = player_pkg::NOTE_DO;
					50: note = player_pkg::NOTE_DO;
					51: note = player_pkg::NOTE_RE;
					52: note = player_pkg::NOTE_DO;
					53: note = player_pkg::NOTE_REST; // closing rest
					default: note = player_pkg::NOTE_REST;
				endcase
			end
			player_pkg::SONG_SKY: begin
				case (pos)
					0:  note = player_pkg::NOTE_REST; // pickup
					1:  note = player_pkg::NOTE_LA;
					2:  note = player_pkg::NOTE_SI;
					3:  note = player_pkg::NOTE_HI_DO;
					4:  note = player_pkg::NOTE_HI_DO;
					5:  note = player_pkg::NOTE_HI_DO;
					6:  note = player_pkg::NOTE_SI;
					7:  note = player_pkg::NOTE_HI_DO;
					8:  note = player_pkg::NOTE_HI_DO;
					9:  note = player_pkg::NOTE_HI_MI;
					10: note = player_pkg::NOTE_HI_MI;
					11: note = player_pkg::NOTE_SI;
					12: note = player_pkg::NOTE_SI;
					13: note = player_pkg::NOTE_SI;
					14: note = player_pkg::NOTE_SI;
					15: note = player_pkg::NOTE_SI;
					16: note = player_pkg::NOTE_SI;
					17: note = player_pkg::NOTE_REST;
					//////////////////////////////////////////////////////////////////////
					18: note = player_pkg::NOTE_MI;
					19: note = player_pkg::NOTE_MI;
					20: note = player_pkg::NOTE_LA;
					21: note = player_pkg::NOTE_LA;
					22: note = player_pkg::NOTE_SO;
					23: note = player_pkg::NOTE_LA;
					24: note = player_pkg::NOTE_LA;
					25: note = player_pkg::NOTE_HI_DO;
					26: note = player_pkg::NOTE_HI_DO;
					27: note = player_pkg::NOTE_SO;
					28: note = player_pkg::NOTE_SO;
					29: note = player_pkg::NOTE_SO;
					30: note = player_pkg::NOTE_SO;
					31: note = player_pkg::NOTE_SO;
					32: note = player_pkg::NOTE_SO;
					33: note = player_pkg::NOTE_REST;
					//////////////////////////////////////////////////////////////////////
					34: note = player_pkg::NOTE_MI;
					35: note = player_pkg::NOTE_MI;
					36: note = player_pkg::NOTE_FA;
					37: note = player_pkg::NOTE_FA;
					38: note = player_pkg::NOTE_FA;
					39: note = player_pkg::NOTE_MI;
					40: note = player_pkg::NOTE_FA;
					41: note = player_pkg::NOTE_HI_DO;
					42: note = player_pkg::NOTE_HI_DO;
					43: note = player_pkg::NOTE_HI_DO;
					44: note = player_pkg::NOTE_MI;
					45: note = player_pkg::NOTE_MI;
					46: note = player_pkg::NOTE_MI;
					47: note = player_pkg::NOTE_MI;
					48: note = player_pkg::NOTE_MI;
					49: note = player_pkg::NOTE_REST;
					//////////////////////////////////////////////////////////////////////
					50: note = player_pkg::NOTE_HI_DO;
					51: note = player_pkg::NOTE_HI_DO;
					52: note = player_pkg::NOTE_HI_DO;
					53: note = player_pkg::NOTE_SI;
					54: note = player_pkg::NOTE_SI;
					55: note = player_pkg::NOTE_SI;
					56: note = player_pkg::NOTE_FA_SHARP;
					57: note = player_pkg::NOTE_FA_SHARP;
					58: note = player_pkg::NOTE_FA_SHARP;
					59: note = player_pkg::NOTE_SI;
					60: note = player_pkg::NOTE_SI;
					61: note = player_pkg::NOTE_SI;
					62: note = player_pkg::NOTE_SI;
					63: note = player_pkg::NOTE_SI;
					64: note = player_pkg::NOTE_SI;
					65: note = player_pkg::NOTE_SI;
					66: note = player_pkg::NOTE_SI;
					67: note = player_pkg::NOTE_REST; // end of first half
					default: note = player_pkg::NOTE_REST;
				endcase
			end
			default: note = player_pkg::NOTE_REST; // none and spare are silent
		endcase
	end

endmodule

`default_nettype wire

//--- src/beat_timer.sv
`timescale 1ns/1ps
`default_nettype none

module beat_timer #(
	parameter int STAR_STEPS = 3,
	parameter int SKY_STEPS  = 2
) (
	input  logic               clk_10Hz,
	input  logic               reset,
	input  logic               valid,
	input  player_pkg::song_e  song,
	output logic               beat,
	output logic               gap
);

	localparam int MAX_STEPS = (STAR_STEPS > SKY_STEPS) ? STAR_STEPS : SKY_STEPS;
	localparam int PH_W      = (MAX_STEPS > 1) ? $clog2(MAX_STEPS) : 1;

	localparam logic [PH_W-1:0] STAR_LAST = PH_W'(STAR_STEPS - 1);
	localparam logic [PH_W-1:0] SKY_LAST  = PH_W'(SKY_STEPS - 1);

	logic [PH_W-1:0] phase;      // step within the note slot
	logic [PH_W-1:0] last_phase; // wrap point of the selected tune

	always_comb begin
		case (song)
			player_pkg::SONG_STAR: last_phase = STAR_LAST;
			player_pkg::SONG_SKY:  last_phase = SKY_LAST;
			default:               last_phase = '0; // one step per slot
		endcase
	end

	always_ff @(posedge clk_10Hz or negedge reset) begin
		if (!reset) begin
			phase <= '0;
		end else if (valid) begin
			if (phase >= last_phase) // also catches a mode change mid slot
				phase <= '0;
			else
				phase <= phase + 1'b1;
		end
	end

	assign beat = valid && (phase == '0); // first step plays the note
	assign gap  = valid && (phase != '0); // rest between notes

endmodule

`default_nettype wire

//--- src/player_pkg.sv
`default_nettype none

package player_pkg;

	// note codes, shared by the ROM, sequencer and divider table
	typedef enum logic [3:0] {
		NOTE_REST     = 4'd0,  // silence
		NOTE_DO       = 4'd1,
		NOTE_RE       = 4'd2,
		NOTE_MI       = 4'd3,
		NOTE_FA       = 4'd4,
		NOTE_SO       = 4'd5,
		NOTE_LA       = 4'd6,
		NOTE_SI       = 4'd7,
		NOTE_HI_DO    = 4'd8,  // upper octave
		NOTE_HI_RE    = 4'd9,
		NOTE_HI_MI    = 4'd10,
		NOTE_HI_FA    = 4'd11,
		NOTE_HI_SO    = 4'd12,
		NOTE_FA_SHARP = 4'd13, // mid octave sharps
		NOTE_SO_SHARP = 4'd14
	} note_e;

	// tune selection from mode_sel
	typedef enum logic [1:0] {
		SONG_NONE  = 2'd0,
		SONG_STAR  = 2'd1,
		SONG_SKY   = 2'd2,
		SONG_SPARE = 2'd3  // plays nothing
	} song_e;

	localparam int DIV_W = 20; // tone generator divider width
	localparam int POS_W = 8;  // note position width

	// stored notes per tune
	localparam logic [POS_W-1:0] STAR_LEN = 8'd54;
	localparam logic [POS_W-1:0] SKY_LEN  = 8'd68;

endpackage

`default_nettype wire
